// File: src/ion_packet_pkg.sv
// ion packet field types, fixed field values and the reading and packet layouts.
package ion_packet_pkg;

	typedef logic [6:0] sync_t;
	typedef logic [7:0] reading_byte_t; // temperature and reference bytes.
	typedef logic [15:0] timestamp_t;
	typedef logic [15:0] ion_sample_t;
	typedef logic [5:0] channel_t;
	typedef logic [23:0] device_id_t;
	typedef logic [7:0] marker_t;

	// fields that never change between packets.
	localparam sync_t SYNC_CODE = 7'd77;
	localparam marker_t MARKER_A = 8'd255;
	localparam marker_t MARKER_B = 8'd239;
	localparam marker_t MARKER_C = 8'd17;
	localparam channel_t CHANNEL_ID = 6'd1;
	localparam device_id_t DEVICE_ID = 24'd4272433;

	// one recorded reading, varying fields only.
	typedef struct packed {
		logic polarity;
		reading_byte_t temperature;
		reading_byte_t reference;
		timestamp_t timestamp;
		ion_sample_t ion_count;
	} sample_t;

	// full 110-bit packet, msb first.
	typedef struct packed {
		device_id_t device_id; // bits 109:86.
		channel_t channel;
		ion_sample_t ion_count;
		marker_t marker_c;
		marker_t marker_b;
		timestamp_t timestamp;
		reading_byte_t reference;
		reading_byte_t temperature;
		marker_t marker_a;
		logic polarity;
		sync_t sync; // bits 6:0.
	} ion_packet_t;

endpackage

// File: src/ion_timing_pkg.sv
// pacing interval, table size, buffer depth and pacer states of the ion sensor simulator.
package ion_timing_pkg;

	localparam int TABLE_LENGTH = 16;
	typedef logic [$clog2(TABLE_LENGTH)-1:0] index_t;

	// cycles between readings.
	localparam int SAMPLE_INTERVAL = 43690;

	localparam int FIFO_DEPTH = 4;
	typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count_t; // 0 to depth inclusive.

	typedef enum logic {
		counting,
		offering
	} pacer_state_t;

endpackage

// File: src/sample_rom.sv
// table of the recorded ion sensor readings, looked up by entry number.
module sample_rom (
	input ion_timing_pkg::index_t index,
	output ion_packet_pkg::sample_t sample
);

	// entry order is polarity, temperature, reference, timestamp, ion count.
	always_comb
	begin
		case (index)
			4'd0:
				sample = '{1'b0, 8'd177, 8'd100, 16'd881, 16'd56110};
			4'd1:
				sample = '{1'b1, 8'd176, 8'd100, 16'd925, 16'd3791};
			4'd2:
				sample = '{1'b0, 8'd177, 8'd100, 16'd962, 16'd63275};
			4'd3:
				sample = '{1'b1, 8'd177, 8'd100, 16'd1011, 16'd24574};
			4'd4:
				sample = '{1'b1, 8'd185, 8'd100, 16'd1045, 16'd40019};
			4'd5:
				sample = '{1'b1, 8'd186, 8'd100, 16'd1094, 16'd50527};
			4'd6:
				sample = '{1'b0, 8'd177, 8'd100, 16'd1136, 16'd60177};
			4'd7:
				sample = '{1'b0, 8'd178, 8'd100, 16'd1178, 16'd47222};
			4'd8:
				sample = '{1'b0, 8'd177, 8'd100, 16'd1220, 16'd42756};
			4'd9:
				sample = '{1'b0, 8'd177, 8'd100, 16'd1262, 16'd61961};
			4'd10:
				sample = '{1'b0, 8'd183, 8'd100, 16'd1304, 16'd7993};
			4'd11:
				sample = '{1'b0, 8'd178, 8'd100, 16'd1346, 16'd17675};
			4'd12:
				sample = '{1'b0, 8'd178, 8'd100, 16'd1380, 16'd57473};
			4'd13:
				sample = '{1'b0, 8'd177, 8'd100, 16'd1430, 16'd53224};
			4'd14:
				sample = '{1'b0, 8'd178, 8'd100, 16'd1472, 16'd61195};
			4'd15:
				sample = '{1'b1, 8'd185, 8'd100, 16'd1514, 16'd46996};
			default:
				sample = '0;
		endcase
	end

endmodule

// File: src/sample_pacer.sv
// interval timer and table sequencer that offers one recorded reading per interval.
module sample_pacer #(
	parameter int interval_cycles = ion_timing_pkg::SAMPLE_INTERVAL
) (
	input logic clock,
	input logic resetn,
	output logic sample_valid,
	input logic sample_ready,
	output ion_packet_pkg::sample_t sample
);

	ion_timing_pkg::pacer_state_t state;
	logic [15:0] interval_count;
	ion_timing_pkg::index_t index;
	logic interval_done;
	logic accepted;

	sample_rom rom (
		.index(index),
		.sample(sample)
	);

	assign interval_done = (interval_count == 16'(interval_cycles - 1));
	assign sample_valid = (state == ion_timing_pkg::offering);
	assign accepted = sample_valid && sample_ready;

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			state <= ion_timing_pkg::counting;
			interval_count <= '0;
			index <= '0;
		end
		else
		begin
			case (state)
				ion_timing_pkg::counting:
				begin
					if (interval_done)
					begin
						interval_count <= '0;
						state <= ion_timing_pkg::offering;
					end
					else
						interval_count <= interval_count + 16'd1;
				end
				ion_timing_pkg::offering:
				begin
					// hold the index until the fifo takes the reading.
					if (accepted)
					begin
						state <= ion_timing_pkg::counting;
						if (index == ion_timing_pkg::index_t'(ion_timing_pkg::TABLE_LENGTH - 1))
							index <= '0; // back to the first entry.
						else
							index <= index + 1'b1;
					end
				end
				default:
					state <= ion_timing_pkg::counting;
			endcase
		end
	end

endmodule

// File: src/reading_fifo.sv
// small circular buffer of readings between the pacer and the packet framer.
module reading_fifo (
	input logic clock,
	input logic resetn,
	input logic sample_valid,
	output logic sample_ready,
	input ion_packet_pkg::sample_t sample,
	output logic head_valid,
	input logic head_ready,
	output ion_packet_pkg::sample_t head
);

	ion_packet_pkg::sample_t buffer [ion_timing_pkg::FIFO_DEPTH];
	logic [$clog2(ion_timing_pkg::FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(ion_timing_pkg::FIFO_DEPTH)-1:0] rd_ptr;
	ion_timing_pkg::fifo_count_t count;
	logic push;
	logic pop;

	assign sample_ready = (count != ion_timing_pkg::fifo_count_t'(ion_timing_pkg::FIFO_DEPTH));
	assign head_valid = (count != '0);
	assign push = sample_valid && sample_ready;
	assign pop = head_valid && head_ready;
	assign head = buffer[rd_ptr];

	always_ff @(posedge clock)
	begin
		if (push)
			buffer[wr_ptr] <= sample;
	end

	// power of two depth, so the pointers wrap on their own.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:
					count <= count + 1'b1;
				2'b01:
					count <= count - 1'b1;
				default:
					count <= count; // none or both.
			endcase
		end
	end

endmodule

// File: src/packet_framer.sv
// builds full ion packets from buffered readings and drives the output handshake.
module packet_framer (
	input logic clock,
	input logic resetn,
	input logic head_valid,
	output logic head_ready,
	input ion_packet_pkg::sample_t head,
	output logic out_valid,
	input logic out_ready,
	output ion_packet_pkg::ion_packet_t out_packet
);

	logic take;

	// room when empty or when the held packet leaves this edge.
	assign head_ready = !out_valid || out_ready;
	assign take = head_valid && head_ready;

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			out_valid <= 1'b0;
		else if (take)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clock)
	begin
		if (take)
		begin
			out_packet.device_id <= ion_packet_pkg::DEVICE_ID;
			out_packet.channel <= ion_packet_pkg::CHANNEL_ID;
			out_packet.ion_count <= head.ion_count;
			out_packet.marker_c <= ion_packet_pkg::MARKER_C;
			out_packet.marker_b <= ion_packet_pkg::MARKER_B;
			out_packet.timestamp <= head.timestamp;
			out_packet.reference <= head.reference;
			out_packet.temperature <= head.temperature;
			out_packet.marker_a <= ion_packet_pkg::MARKER_A;
			out_packet.polarity <= head.polarity;
			out_packet.sync <= ion_packet_pkg::SYNC_CODE;
		end
	end

endmodule

// File: src/ion_sensor_sim.sv
// ion sensor simulator top, pacer feeding a reading fifo feeding the packet framer.
module ion_sensor_sim #(
	parameter int interval_cycles = ion_timing_pkg::SAMPLE_INTERVAL
) (
	input logic clock,
	input logic resetn,
	output logic out_valid,
	input logic out_ready,
	output ion_packet_pkg::ion_packet_t out_packet
);

	logic sample_valid;
	logic sample_ready;
	ion_packet_pkg::sample_t sample;
	logic head_valid;
	logic head_ready;
	ion_packet_pkg::sample_t head;

	sample_pacer #(
		.interval_cycles(interval_cycles)
	) pacer (
		.clock(clock),
		.resetn(resetn),
		.sample_valid(sample_valid),
		.sample_ready(sample_ready),
		.sample(sample)
	);

	reading_fifo fifo (
		.clock(clock),
		.resetn(resetn),
		.sample_valid(sample_valid),
		.sample_ready(sample_ready),
		.sample(sample),
		.head_valid(head_valid),
		.head_ready(head_ready),
		.head(head)
	);

	packet_framer framer (
		.clock(clock),
		.resetn(resetn),
		.head_valid(head_valid),
		.head_ready(head_ready),
		.head(head),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_packet(out_packet)
	);

endmodule

// File: verification/ion_sensor_sim_assertions.sv
// output handshake and packet framing assertions for the ion sensor simulator top.
module ion_sensor_sim_assertions (
	input logic clock,
	input logic resetn,
	input logic out_valid,
	input logic out_ready,
	input ion_packet_pkg::ion_packet_t out_packet
);

	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0; // failed assertion count.

	// no packet while in reset.
	quiet_in_reset: assert property (@(posedge clock) !resetn |-> !out_valid)
	else
	begin
		failures++;
		$error("out_valid high during reset");
	end

	// stalled packet stays offered and unchanged.
	held_while_stalled: assert property (@(posedge clock) disable iff (!resetn)
		out_valid && !out_ready |=> out_valid && $stable(out_packet))
	else
	begin
		failures++;
		$error("out_valid or out_packet changed while out_ready was low");
	end

	sync_field: assert property (@(posedge clock) disable iff (!resetn)
		out_valid |-> out_packet.sync == ion_packet_pkg::SYNC_CODE)
	else
	begin
		failures++;
		$error("sync field of an offered packet is %0d", out_packet.sync);
	end

endmodule

bind ion_sensor_sim ion_sensor_sim_assertions protocol_checks (
	.clock(clock),
	.resetn(resetn),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.out_packet(out_packet)
);

// File: verification/ion_sensor_sim_tb.sv
// testbench for the ion sensor simulator that checks played back packets under output stalls.
module ion_sensor_sim_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLOCK_PERIOD = 8;
	localparam int INTERVAL = 20;
	localparam int RESET_CYCLES = 10;
	localparam int ROWS = 20;
	localparam int RECORDED = 16;
	localparam int WAIT_LIMIT = 200;
	localparam int MIN_GAP = INTERVAL + 1;

	// expected reading of one packet and its output stall.
	typedef struct packed {
		ion_packet_pkg::sample_t reading;
		logic [7:0] stall; // cycles out_ready stays low.
	} table_row_t;

	logic clock;
	logic resetn;
	logic out_valid;
	logic out_ready;
	ion_packet_pkg::ion_packet_t out_packet;

	ion_packet_pkg::sample_t recorded [RECORDED];
	table_row_t stimulus [ROWS];
	int value_errors;
	int protocol_errors;
	int delivered;
	bit timed_out;

	ion_sensor_sim #(
		.interval_cycles(INTERVAL)
	) uut (
		.clock(clock),
		.resetn(resetn),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_packet(out_packet)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// recorded readings and then the rows that walk past the end of the table.
	task load_table();
		begin
			recorded[0] = {1'b0, 8'd177, 8'd100, 16'd881, 16'd56110};
			recorded[1] = {1'b1, 8'd176, 8'd100, 16'd925, 16'd3791};
			recorded[2] = {1'b0, 8'd177, 8'd100, 16'd962, 16'd63275};
			recorded[3] = {1'b1, 8'd177, 8'd100, 16'd1011, 16'd24574};
			recorded[4] = {1'b1, 8'd185, 8'd100, 16'd1045, 16'd40019};
			recorded[5] = {1'b1, 8'd186, 8'd100, 16'd1094, 16'd50527};
			recorded[6] = {1'b0, 8'd177, 8'd100, 16'd1136, 16'd60177};
			recorded[7] = {1'b0, 8'd178, 8'd100, 16'd1178, 16'd47222};
			recorded[8] = {1'b0, 8'd177, 8'd100, 16'd1220, 16'd42756};
			recorded[9] = {1'b0, 8'd177, 8'd100, 16'd1262, 16'd61961};
			recorded[10] = {1'b0, 8'd183, 8'd100, 16'd1304, 16'd7993};
			recorded[11] = {1'b0, 8'd178, 8'd100, 16'd1346, 16'd17675};
			recorded[12] = {1'b0, 8'd178, 8'd100, 16'd1380, 16'd57473};
			recorded[13] = {1'b0, 8'd177, 8'd100, 16'd1430, 16'd53224};
			recorded[14] = {1'b0, 8'd178, 8'd100, 16'd1472, 16'd61195};
			recorded[15] = {1'b1, 8'd185, 8'd100, 16'd1514, 16'd46996};
			for (int k = 0; k < ROWS; k++)
			begin
				stimulus[k].reading = recorded[k % RECORDED];
				// stalls stay shorter than one interval.
				if (k % 3 == 1)
					stimulus[k].stall = 8'(1 + ($urandom % 12));
				else
					stimulus[k].stall = 8'd0;
			end
		end
	endtask

	task check_value(input string name, input logic [31:0] got, input logic [31:0] expected);
		begin
			assert (got == expected)
			else
			begin
				value_errors++;
				$display("[ERROR] %0d ns: %s = %0d, expected %0d", $time, name, got, expected);
			end
		end
	endtask

	task check_packet(input ion_packet_pkg::ion_packet_t packet,
		input ion_packet_pkg::sample_t expected);
		begin
			check_value("out_packet.sync", 32'(packet.sync), 32'd77);
			check_value("out_packet.polarity", 32'(packet.polarity), 32'(expected.polarity));
			check_value("out_packet.marker_a", 32'(packet.marker_a), 32'd255);
			check_value("out_packet.temperature", 32'(packet.temperature),
				32'(expected.temperature));
			check_value("out_packet.reference", 32'(packet.reference), 32'(expected.reference));
			check_value("out_packet.timestamp", 32'(packet.timestamp), 32'(expected.timestamp));
			check_value("out_packet.marker_b", 32'(packet.marker_b), 32'd239);
			check_value("out_packet.marker_c", 32'(packet.marker_c), 32'd17);
			check_value("out_packet.ion_count", 32'(packet.ion_count), 32'(expected.ion_count));
			check_value("out_packet.channel", 32'(packet.channel), 32'd1);
			check_value("out_packet.device_id", 32'(packet.device_id), 32'd4272433);
		end
	endtask

	// one stalled cycle where the packet must sit still.
	task check_held(input ion_packet_pkg::ion_packet_t held);
		begin
			assert (out_valid)
			else
			begin
				protocol_errors++;
				$display("[ERROR] %0d ns: out_valid = %0d, expected 1", $time, out_valid);
			end
			assert (out_packet == held)
			else
			begin
				value_errors++;
				$display("[ERROR] %0d ns: out_packet = %h, expected %h", $time, out_packet, held);
			end
		end
	endtask

	task wait_for_packet(input int row);
		int cycles;
		begin
			cycles = 0;
			@(posedge clock);
			while (!out_valid && cycles < WAIT_LIMIT)
			begin
				@(posedge clock);
				cycles++;
			end
			if (!out_valid)
			begin
				timed_out = 1'b1;
				protocol_errors++;
				$display("timeout: no packet for row %0d within %0d cycles", row, WAIT_LIMIT);
			end
		end
	endtask

	initial
	begin
		int row;
		int gap;
		time last_delivery;
		ion_packet_pkg::ion_packet_t held;

		clock = 1'b0;
		resetn = 1'b0;
		out_ready = 1'b0;
		value_errors = 0;
		protocol_errors = 0;
		delivered = 0;
		timed_out = 1'b0;
		last_delivery = 0;
		void'($urandom(32'h42b4));
		load_table();

		repeat (RESET_CYCLES)
		begin
			@(posedge clock);
			check_value("out_valid", 32'(out_valid), 32'd0);
		end
		resetn <= 1'b1;
		repeat (4)
		begin
			@(posedge clock);
			check_value("out_valid", 32'(out_valid), 32'd0); // nothing before first interval.
		end

		for (row = 0; row < ROWS && !timed_out; row++)
		begin
			out_ready <= (stimulus[row].stall == 8'd0);
			wait_for_packet(row);
			if (!timed_out)
			begin
				held = out_packet;
				if (stimulus[row].stall != 8'd0)
				begin
					repeat (stimulus[row].stall - 8'd1)
					begin
						@(posedge clock);
						check_held(held);
					end
					out_ready <= 1'b1;
					@(posedge clock);
					check_held(held);
				end
				// handshake completes on this edge.
				check_packet(held, stimulus[row].reading);
				if ((row > 0) && (stimulus[row - 1].stall == 8'd0))
				begin
					gap = int'(($time - last_delivery) / CLOCK_PERIOD);
					assert (gap >= MIN_GAP)
					else
					begin
						protocol_errors++;
						$display("[ERROR] %0d ns: delivery gap = %0d cycles, expected at least %0d",
							$time, gap, MIN_GAP);
					end
				end
				last_delivery = $time;
				delivered++;
			end
		end

		repeat (2) @(posedge clock);
		$display("%0d packets checked, %0d value, %0d protocol and %0d assertion errors",
			delivered, value_errors, protocol_errors, uut.protocol_checks.failures);
		if (value_errors + protocol_errors + uut.protocol_checks.failures == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: files.f
src/ion_packet_pkg.sv
src/ion_timing_pkg.sv
src/sample_rom.sv
src/sample_pacer.sv
src/reading_fifo.sv
src/packet_framer.sv
src/ion_sensor_sim.sv
verification/ion_sensor_sim_assertions.sv
verification/ion_sensor_sim_tb.sv

// File: Makefile
# Verilator build and run of the ion sensor simulator testbench.

TOP = ion_sensor_sim_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module $(TOP)

# passes only when the pass message shows up in the simulator output.
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
